// File: verilog/rvfi_trace_pkg.sv
`default_nettype none

package rvfi_trace_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // Data and address width of the core
  localparam int XLEN = 32;

  // Register index and byte mask widths
  localparam int REG_ADDR_W = 5;
  localparam int MEM_MASK_W = XLEN / 8;

  // Instruction table geometry
  localparam int ITB_ENTRIES = 16;
  localparam int ITB_INDEX_W = 4;

  // Source info field widths
  localparam int FUNC_ID_W = 8;
  localparam int LINE_W = 16;

  // Trace FIFO geometry, count needs room for the full value
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Statistics counters
  localparam int CNT_W = 16;

  // Line number reported for a pc that is not in the table
  localparam logic [LINE_W-1:0] UNKNOWN_LINE = {LINE_W{1'b1}};

  //////////////////////////////
  // Records
  //////////////////////////////

  // One retired instruction as seen on RVFI, single memory lane
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MEM_MASK_W-1:0] mem_rmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [MEM_MASK_W-1:0] mem_wmask;
    logic [XLEN-1:0]       mem_wdata;
  } rvfi_retire_t;

  // Instruction table entry, code address to source info
  typedef struct packed {
    logic [XLEN-1:0]      addr;
    logic [FUNC_ID_W-1:0] func_id;
    logic [LINE_W-1:0]    line;
    logic [XLEN-1:0]      mcode;
  } itb_entry_t;

  // Retirement joined with its table lookup
  typedef struct packed {
    rvfi_retire_t         retire;
    logic                 known;
    logic [FUNC_ID_W-1:0] func_id;
    logic [LINE_W-1:0]    line;
    logic [XLEN-1:0]      mcode;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: verilog/itb_table.sv
`default_nettype none

module itb_table
  import rvfi_trace_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,

  // Load port
  input  wire logic                   itb_wr,
  input  wire logic [ITB_INDEX_W-1:0] itb_wr_index,
  input  wire itb_entry_t             itb_wr_entry,

  // Lookup request from the tracer
  input  wire logic                   lookup_valid,
  input  wire logic [XLEN-1:0]        lookup_pc,

  // Registered lookup result
  output      logic                   hit,
  output      itb_entry_t             hit_entry
);

  // Slot storage and per-slot valid bits
  itb_entry_t               slot_q [ITB_ENTRIES];
  logic [ITB_ENTRIES-1:0]   slot_valid;

  // Address compare results
  logic [ITB_ENTRIES-1:0]   match;
  logic                     match_found;
  logic [ITB_INDEX_W-1:0]   match_index;

  //////////////////////////////
  // Write side
  //////////////////////////////

  // Valid bits are the only table state cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
    end else if (itb_wr) begin
      slot_valid[itb_wr_index] <= 1'b1;
    end
  end

  // Entry contents, overwrite replaces the whole slot
  always_ff @(posedge clk) begin
    if (itb_wr) begin
      slot_q[itb_wr_index] <= itb_wr_entry;
    end
  end

  //////////////////////////////
  // Lookup side
  //////////////////////////////

  // Compare pc against every valid slot in parallel
  always_comb begin
    for (int i = 0; i < ITB_ENTRIES; i++) begin
      match[i] = slot_valid[i] && (slot_q[i].addr == lookup_pc);
    end
  end

  // Priority pick
  // Scan from the top so the lowest matching index is the last one written
  always_comb begin
    match_found = 1'b0;
    match_index = '0;
    for (int i = ITB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        match_found = 1'b1;
        match_index = ITB_INDEX_W'(i);
      end
    end
  end

  // Hit flag, only raised for an actual request
  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= lookup_valid && match_found;
    end
  end

  // Entry payload
  // Reads the pre-write contents when a load lands on the same edge
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      hit_entry <= slot_q[match_index];
    end
  end

endmodule

`default_nettype wire

// File: verilog/retire_tracer.sv
`default_nettype none

module retire_tracer
  import rvfi_trace_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst,

  // Retirement port, one-cycle strobe
  input  wire logic             rvfi_valid,
  input  wire rvfi_retire_t     rvfi,

  // Table lookup
  output      logic             lookup_valid,
  output      logic [XLEN-1:0]  lookup_pc,
  input  wire logic             hit,
  input  wire itb_entry_t       hit_entry,

  // Trace FIFO write side
  input  wire logic             full,
  output      logic             push,
  output      trace_rec_t       push_rec,

  // Statistics
  output      logic [CNT_W-1:0] retired_count,
  output      logic [CNT_W-1:0] unknown_count,
  output      logic [CNT_W-1:0] dropped_count
);

  // Stage 1, retirement captured at the sampling edge
  logic         s1_valid;
  rvfi_retire_t s1_ret;

  // Stage 2, lookup result arrives alongside
  logic         s2_valid;
  rvfi_retire_t s2_ret;

  // Counter step that holds at all ones
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] value);
    if (value == {CNT_W{1'b1}}) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  //////////////////////////////
  // Stage 1
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= rvfi_valid;
    end
  end

  // Payload only moves on a real retirement
  always_ff @(posedge clk) begin
    if (rvfi_valid) begin
      s1_ret <= rvfi;
    end
  end

  // Table lookup issued straight from the stage 1 register
  assign lookup_valid = s1_valid;
  assign lookup_pc    = s1_ret.pc;

  //////////////////////////////
  // Stage 2
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_ret <= s1_ret;
    end
  end

  // Join RVFI fields with the table result
  always_comb begin
    push_rec.retire = s2_ret;
    if (hit) begin
      push_rec.known   = 1'b1;
      push_rec.func_id = hit_entry.func_id;
      push_rec.line    = hit_entry.line;
      push_rec.mcode   = hit_entry.mcode;
    end else begin
      // Unknown pc, fixed filler values
      push_rec.known   = 1'b0;
      push_rec.func_id = '0;
      push_rec.line    = UNKNOWN_LINE;
      push_rec.mcode   = '0;
    end
  end

  // No stall path back to the core, a full FIFO drops the record
  assign push = s2_valid && !full;

  // Statistics, all update on the push edge
  always_ff @(posedge clk) begin
    if (rst) begin
      retired_count <= '0;
      unknown_count <= '0;
      dropped_count <= '0;
    end else if (s2_valid) begin
      retired_count <= sat_inc(retired_count);
      if (!hit) begin
        unknown_count <= sat_inc(unknown_count);
      end
      if (full) begin
        dropped_count <= sat_inc(dropped_count);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/trace_fifo.sv
`default_nettype none

module trace_fifo
  import rvfi_trace_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,

  // Write side, producer checks full first
  input  wire logic       push,
  input  wire trace_rec_t push_rec,

  // Read side, show-ahead
  input  wire logic       pop,
  output      logic       full,
  output      logic       trace_valid,
  output      trace_rec_t trace_rec
);

  // Record storage
  trace_rec_t              mem_q [FIFO_DEPTH];

  // Pointers and occupancy
  logic [FIFO_PTR_W-1:0]   wr_ptr;
  logic [FIFO_PTR_W-1:0]   rd_ptr;
  logic [FIFO_CNT_W-1:0]   count;

  // Pop on an empty FIFO does nothing
  logic                    do_pop;

  assign do_pop      = pop && trace_valid;
  assign full        = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign trace_valid = (count != '0);

  // Head of queue is always on the output
  assign trace_rec   = mem_q[rd_ptr];

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr] <= push_rec;
    end
  end

  // Pointer and count update, push and pop may coincide
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvfi_trace_unit.sv
`default_nettype none

module rvfi_trace_unit
  import rvfi_trace_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,

  // Core retirement port
  input  wire logic                   rvfi_valid,
  input  wire rvfi_retire_t           rvfi,

  // Instruction table load port
  input  wire logic                   itb_wr,
  input  wire logic [ITB_INDEX_W-1:0] itb_wr_index,
  input  wire itb_entry_t             itb_wr_entry,

  // Trace output, drained by the consumer
  input  wire logic                   trace_pop,
  output      logic                   trace_valid,
  output      trace_rec_t             trace_rec,

  // Statistics
  output      logic [CNT_W-1:0]       retired_count,
  output      logic [CNT_W-1:0]       unknown_count,
  output      logic [CNT_W-1:0]       dropped_count
);

  // Tracer to table
  logic             lookup_valid;
  logic [XLEN-1:0]  lookup_pc;
  logic             hit;
  itb_entry_t       hit_entry;

  // Tracer to FIFO
  logic             push;
  trace_rec_t       push_rec;
  logic             full;

  // Address to source info map
  itb_table itb_table_inst (
    .clk          (clk),
    .rst          (rst),
    .itb_wr       (itb_wr),
    .itb_wr_index (itb_wr_index),
    .itb_wr_entry (itb_wr_entry),
    .lookup_valid (lookup_valid),
    .lookup_pc    (lookup_pc),
    .hit          (hit),
    .hit_entry    (hit_entry)
  );

  // Two-stage join and statistics
  retire_tracer retire_tracer_inst (
    .clk           (clk),
    .rst           (rst),
    .rvfi_valid    (rvfi_valid),
    .rvfi          (rvfi),
    .lookup_valid  (lookup_valid),
    .lookup_pc     (lookup_pc),
    .hit           (hit),
    .hit_entry     (hit_entry),
    .full          (full),
    .push          (push),
    .push_rec      (push_rec),
    .retired_count (retired_count),
    .unknown_count (unknown_count),
    .dropped_count (dropped_count)
  );

  // Record queue toward the consumer
  trace_fifo trace_fifo_inst (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .push_rec    (push_rec),
    .pop         (trace_pop),
    .full        (full),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec)
  );

endmodule

`default_nettype wire

// File: verification/rvfi_trace_unit_properties.sv
`default_nettype none

module rvfi_trace_unit_properties (
  input wire logic clk,
  input wire logic rst,
  input wire logic s1_valid,
  input wire logic s2_valid,
  input wire logic lookup_valid,
  input wire logic hit,
  input wire logic push,
  input wire logic full,
  input wire logic trace_pop,
  input wire logic trace_valid
);

  //////////////////////////////
  // Tracer pipeline
  //////////////////////////////

  // The FIFO never sees a push while full
  push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push issued while the FIFO is full");

  // Stage 2 follows stage 1 by one cycle
  s2_after_s1: assert property (@(posedge clk) disable iff (rst) s1_valid |=> s2_valid)
    else $error("stage 1 entry did not reach stage 2");
  s2_from_s1: assert property (@(posedge clk) disable iff (rst) s2_valid |-> $past(s1_valid))
    else $error("stage 2 valid without a stage 1 entry");

  // Table answers on the next edge
  hit_defined: assert property (@(posedge clk) disable iff (rst)
    lookup_valid |=> !$isunknown(hit))
    else $error("hit undefined after a lookup");

  // Consumer side
  pop_not_empty: assert property (@(posedge clk) disable iff (rst) trace_pop |-> trace_valid)
    else $error("pop issued while the FIFO is empty");

endmodule

`default_nettype wire

// File: verification/rvfi_trace_unit_tb.sv
`default_nettype none

module rvfi_trace_unit_tb
  import rvfi_trace_pkg::*;
();

  logic                   clk;
  logic                   rst;
  logic                   rvfi_valid;
  rvfi_retire_t           rvfi;
  logic                   itb_wr;
  logic [ITB_INDEX_W-1:0] itb_wr_index;
  itb_entry_t             itb_wr_entry;
  logic                   trace_pop;
  logic                   trace_valid;
  trace_rec_t             trace_rec;
  logic [CNT_W-1:0]       retired_count;
  logic [CNT_W-1:0]       unknown_count;
  logic [CNT_W-1:0]       dropped_count;

  // Model of the table writes and the expected output
  itb_entry_t             model_tab [ITB_ENTRIES];
  logic [ITB_ENTRIES-1:0] model_valid;
  trace_rec_t             exp_q [$];
  logic [CNT_W-1:0]       exp_retired;
  logic [CNT_W-1:0]       exp_unknown;
  logic [CNT_W-1:0]       exp_dropped;
  logic                   drain_en;
  logic [31:0]            lfsr;
  int                     errors;
  int                     tests;
  int                     failed;

  rvfi_trace_unit rvfi_trace_unit_inst (.*);

  bind rvfi_trace_unit rvfi_trace_unit_properties props_inst (
    .clk          (clk),
    .rst          (rst),
    .s1_valid     (retire_tracer_inst.s1_valid),
    .s2_valid     (retire_tracer_inst.s2_valid),
    .lookup_valid (lookup_valid),
    .hit          (hit),
    .push         (push),
    .full         (full),
    .trace_pop    (trace_pop),
    .trace_valid  (trace_valid)
  );

  // Starts high so the first falling edge is a real one
  initial begin
    clk = 1'b1;
    forever begin
      #2 clk = ~clk;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic rvfi_retire_t rand_retire(input logic [XLEN-1:0] pc);
    rvfi_retire_t r;
    r.pc        = pc;
    r.rs1_addr  = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    r.rs1_rdata = rand_bits(XLEN);
    r.rs2_addr  = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    r.rs2_rdata = rand_bits(XLEN);
    r.rd_addr   = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    r.rd_wdata  = rand_bits(XLEN);
    r.mem_addr  = rand_bits(XLEN);
    r.mem_rmask = MEM_MASK_W'(rand_bits(MEM_MASK_W));
    r.mem_rdata = rand_bits(XLEN);
    r.mem_wmask = MEM_MASK_W'(rand_bits(MEM_MASK_W));
    r.mem_wdata = rand_bits(XLEN);
    return r;
  endfunction

  function automatic itb_entry_t rand_entry(input logic [XLEN-1:0] addr);
    itb_entry_t e;
    e.addr    = addr;
    e.func_id = FUNC_ID_W'(rand_bits(FUNC_ID_W));
    e.line    = LINE_W'(rand_bits(LINE_W));
    e.mcode   = rand_bits(XLEN);
    return e;
  endfunction

  // Expected record where the lowest valid slot with a matching address wins
  function automatic trace_rec_t expect_rec(input rvfi_retire_t r,
                                            input itb_entry_t tab [ITB_ENTRIES],
                                            input logic [ITB_ENTRIES-1:0] tab_valid);
    trace_rec_t e;
    e.retire  = r;
    e.known   = 1'b0;
    e.func_id = '0;
    e.line    = UNKNOWN_LINE;
    e.mcode   = '0;
    for (int i = 0; i < ITB_ENTRIES; i++) begin
      if (!e.known && tab_valid[i] && tab[i].addr == r.pc) begin
        e.known   = 1'b1;
        e.func_id = tab[i].func_id;
        e.line    = tab[i].line;
        e.mcode   = tab[i].mcode;
      end
    end
    return e;
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
    if (got !== exp) begin
      $display("Error %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_counters();
    check_count("retired_count", retired_count, exp_retired);
    check_count("unknown_count", unknown_count, exp_unknown);
    check_count("dropped_count", dropped_count, exp_dropped);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic timed_out(input string msg);
    $display("Timeout: %s", msg);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before) begin
      failed++;
      $display("test %s failed", name);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  //////////////////////////////
  // Bus tasks entered on a falling edge
  //////////////////////////////

  task automatic load_entry(input int idx, input itb_entry_t e);
    itb_wr           = 1'b1;
    itb_wr_index     = ITB_INDEX_W'(idx);
    itb_wr_entry     = e;
    model_tab[idx]   = e;
    model_valid[idx] = 1'b1;
    @(negedge clk);
    itb_wr = 1'b0;
  endtask

  // Keep clear means the FIFO is expected to drop this record
  task automatic retire(input rvfi_retire_t r, input logic keep);
    trace_rec_t e;
    e          = expect_rec(r, model_tab, model_valid);
    rvfi_valid = 1'b1;
    rvfi       = r;
    exp_retired++;
    if (!e.known) exp_unknown++;
    if (keep) exp_q.push_back(e);
    else exp_dropped++;
    @(negedge clk);
    rvfi_valid = 1'b0;
  endtask

  // Retire into an empty FIFO and measure the edge count to trace_valid
  task automatic retire_timed(input rvfi_retire_t r);
    int n;
    retire(r, 1'b1);
    n = 1;
    while (!trace_valid) begin
      if (n == 10) timed_out("trace_valid never rose after a retirement");
      @(negedge clk);
      n++;
    end
    if (n != 3) report_problem($sformatf("trace_valid rose %0d cycles after rvfi_valid", n - 1));
  endtask

  // Every issued retirement has reached the counters
  task automatic wait_settled();
    int n;
    n = 0;
    while (retired_count != exp_retired) begin
      if (n == 50) timed_out("retired_count did not reach the issued count");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 || trace_valid || retired_count != exp_retired) begin
      if (n == 200) timed_out("trace FIFO did not drain");
      @(negedge clk);
      n++;
    end
  endtask

  // Consumer that pops and compares every record while draining is on
  initial begin
    forever begin
      @(negedge clk);
      trace_pop = 1'b0;
      if (!rst && drain_en && trace_valid) begin
        if (exp_q.size() == 0) report_problem("record popped with none expected");
        else check_rec("trace_rec", trace_rec, exp_q.pop_front());
        trace_pop = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int           e0;
    rvfi_retire_t r;
    trace_rec_t   e;
    itb_entry_t   ent;
    lfsr         = 32'd92878;
    rst          = 1'b1;
    rvfi_valid   = 1'b0;
    rvfi         = '0;
    itb_wr       = 1'b0;
    itb_wr_index = '0;
    itb_wr_entry = '0;
    trace_pop    = 1'b0;
    drain_en     = 1'b1;
    model_valid  = '0;
    exp_retired  = '0;
    exp_unknown  = '0;
    exp_dropped  = '0;
    errors       = 0;
    tests        = 0;
    failed       = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    if ($bits(rvfi_trace_unit_inst.retired_count) != CNT_W ||
        $bits(rvfi_trace_unit_inst.unknown_count) != CNT_W ||
        $bits(rvfi_trace_unit_inst.dropped_count) != CNT_W) begin
      report_problem("counter width differs from CNT_W");
    end

    // Known pcs retired one at a time into an empty FIFO
    e0 = errors;
    for (int i = 0; i < 4; i++) load_entry(i, rand_entry(rand_bits(XLEN - 2) << 2));
    for (int i = 0; i < 4; i++) begin
      retire_timed(rand_retire(model_tab[i].addr));
      wait_drained();
    end
    check_counters();
    end_test("known_lookup", e0);

    // Pcs absent from the table
    e0 = errors;
    repeat (6) begin
      do begin
        r = rand_retire(rand_bits(XLEN - 2) << 2);
        e = expect_rec(r, model_tab, model_valid);
      end while (e.known);
      retire(r, 1'b1);
    end
    wait_drained();
    check_counters();
    end_test("unknown_pc", e0);

    // One retirement per cycle with a continuous drain
    e0 = errors;
    repeat (20) begin
      retire(rand_retire(rand_bits(1) ? model_tab[rand_bits(2)].addr : rand_bits(XLEN - 2) << 2),
             1'b1);
    end
    wait_drained();
    check_counters();
    end_test("back_to_back", e0);

    // Without popping only the oldest FIFO_DEPTH records survive
    e0 = errors;
    drain_en = 1'b0;
    for (int i = 0; i < FIFO_DEPTH + 5; i++) begin
      retire(rand_retire(model_tab[rand_bits(2)].addr), i < FIFO_DEPTH);
    end
    wait_settled();
    drain_en = 1'b1;
    wait_drained();
    check_counters();
    end_test("overflow", e0);

    // Slot overwrite followed by one address held in two slots
    e0 = errors;
    ent = rand_entry(rand_bits(XLEN - 2) << 2);
    load_entry(5, ent);
    retire(rand_retire(ent.addr), 1'b1);
    load_entry(5, rand_entry(ent.addr));
    retire(rand_retire(ent.addr), 1'b1);
    ent = rand_entry(rand_bits(XLEN - 2) << 2);
    load_entry(12, ent);
    load_entry(10, rand_entry(ent.addr));
    retire(rand_retire(ent.addr), 1'b1);
    wait_drained();
    check_counters();
    end_test("table_rules", e0);

    // Mid-run reset clears the table, the FIFO and the counters
    // Records are left waiting in the FIFO so the flush is visible
    e0 = errors;
    drain_en = 1'b0;
    for (int i = 0; i < 3; i++) retire(rand_retire(model_tab[i].addr), 1'b1);
    wait_settled();
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    model_valid = '0;
    exp_retired = '0;
    exp_unknown = '0;
    exp_dropped = '0;
    exp_q.delete();
    drain_en = 1'b1;
    if (trace_valid !== 1'b0) report_problem("trace_valid is not low after reset");
    check_counters();
    retire(rand_retire(model_tab[0].addr), 1'b1);
    wait_drained();
    check_counters();
    end_test("reset", e0);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
verilog/rvfi_trace_pkg.sv
verilog/itb_table.sv
verilog/retire_tracer.sv
verilog/trace_fifo.sv
verilog/rvfi_trace_unit.sv
verification/rvfi_trace_unit_properties.sv
verification/rvfi_trace_unit_tb.sv

// File: Bender.yml
package:
  name: rvfi_trace_unit

sources:
  - verilog/rvfi_trace_pkg.sv
  - verilog/itb_table.sv
  - verilog/retire_tracer.sv
  - verilog/trace_fifo.sv
  - verilog/rvfi_trace_unit.sv
  - target: simulation
    files:
      - verification/rvfi_trace_unit_properties.sv
      - verification/rvfi_trace_unit_tb.sv
